// ==== logic/portalPkg.sv ====
`default_nettype none

package portalPkg;

  localparam int wordWidth = 32;
  localparam int idWidth = 6;
  localparam int addrWidth = 13;
  localparam int lenWidth = 4;
  localparam int offsetWidth = 5;
  localparam int chanWidth = 2;

  typedef logic [wordWidth-1:0] word_t;
  typedef logic [idWidth-1:0] axiId_t;
  typedef logic [addrWidth-1:0] busAddr_t;
  typedef logic [lenWidth-1:0] burstLen_t;
  typedef logic [offsetWidth-1:0] pageOffset_t;
  typedef logic [chanWidth-1:0] channel_t;

  // Offset stride of one word beat
  localparam pageOffset_t beatStep = 5'd4;

  localparam word_t numTiles = 32'd1;
  localparam word_t numPortals = 32'd2;
  localparam word_t requestPortalId = 32'd6;
  localparam word_t indicationPortalId = 32'd5;
  localparam word_t fillWord = 32'h005A05A0;

  typedef struct packed {
    logic requestSide;
    logic controlPage;
    channel_t channel;
    pageOffset_t offset;
  } portalAddr_t;

  typedef enum logic [1:0] {
    IDLE,
    BURST,
    RESP
  } burstState_t;

  typedef enum pageOffset_t {
    INT_STATUS = 5'h00,
    INT_ENABLE = 5'h04,
    NUM_TILES = 5'h08,
    QUEUE_STATUS = 5'h0C,
    PORTAL_ID = 5'h10,
    NUM_PORTALS = 5'h14
  } ctrlReg_e;

  function automatic portalAddr_t decodeAddr(input busAddr_t addr);
    portalAddr_t result;
    result.requestSide = addr[addrWidth-1];
    // Page zero holds the control registers
    result.controlPage = addr[addrWidth-2:offsetWidth] == '0;
    // User pages start at one, so channel 0 sits on page 1
    result.channel = addr[offsetWidth+chanWidth-1:offsetWidth] - channel_t'(1);
    result.offset = addr[offsetWidth-1:0];
    return result;
  endfunction

endpackage

`default_nettype wire

// ==== logic/portalBeatIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface portalBeatIf;
  import portalPkg::*;

  logic valid;
  logic requestSide;
  logic controlPage;
  channel_t channel;
  pageOffset_t offset;
  word_t wData;
  // Answer from the register block, same cycle
  word_t rData;

  modport issuer (
    output valid, requestSide, controlPage, channel, offset, wData,
    input rData
  );

  modport target (
    input valid, requestSide, controlPage, channel, offset, wData,
    output rData
  );

endinterface

`default_nettype wire

// ==== logic/readBurstEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

module readBurstEngine (
  input logic CLK,
  input logic RST_N,
  input logic arValid,
  output logic arReady,
  input portalPkg::busAddr_t arAddr,
  input portalPkg::burstLen_t arLen,
  input portalPkg::axiId_t arId,
  output logic rValid,
  input logic rReady,
  output portalPkg::word_t rData,
  output portalPkg::axiId_t rId,
  output logic rLast,
  portalBeatIf.issuer beat
);
  import portalPkg::*;

  burstState_t state;
  portalAddr_t page;
  burstLen_t remaining;
  axiId_t burstId;
  logic arFire;
  logic issue;

  // New burst only once the R slot has drained
  assign arReady = (state == IDLE) && !rValid;
  assign arFire = arValid && arReady;
  assign issue = (state == BURST) && (!rValid || rReady);

  assign beat.valid = issue;
  assign beat.requestSide = page.requestSide;
  assign beat.controlPage = page.controlPage;
  assign beat.channel = page.channel;
  assign beat.offset = page.offset;
  assign beat.wData = '0;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= IDLE;
      rValid <= 1'b0;
    end else begin
      case (state)
        IDLE: if (arFire) state <= BURST;
        BURST: if (issue && remaining == '0) state <= IDLE;
        default: state <= IDLE;
      endcase
      if (issue) begin
        rValid <= 1'b1;
      end else if (rReady) begin
        rValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (arFire) begin
      page <= decodeAddr(arAddr);
      remaining <= arLen;
      burstId <= arId;
    end else if (issue) begin
      // Wraps inside the page
      page.offset <= page.offset + beatStep;
      remaining <= remaining - burstLen_t'(1);
    end
    if (issue) begin
      rData <= beat.rData;
      rId <= burstId;
      rLast <= remaining == '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/writeBurstEngine.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeBurstEngine (
  input logic CLK,
  input logic RST_N,
  input logic awValid,
  output logic awReady,
  input portalPkg::busAddr_t awAddr,
  input portalPkg::burstLen_t awLen,
  input portalPkg::axiId_t awId,
  input logic wValid,
  output logic wReady,
  input portalPkg::word_t wData,
  output logic bValid,
  input logic bReady,
  output portalPkg::axiId_t bId,
  portalBeatIf.issuer beat
);
  import portalPkg::*;

  burstState_t state;
  portalAddr_t page;
  burstLen_t remaining;
  axiId_t burstId;
  logic awFire;
  logic wFire;
  logic bFire;

  assign awReady = state == IDLE;
  assign wReady = state == BURST;
  assign bValid = state == RESP;
  assign bId = burstId;

  assign awFire = awValid && awReady;
  assign wFire = wValid && wReady;
  assign bFire = bValid && bReady;

  // Every accepted data word is a beat
  assign beat.valid = wFire;
  assign beat.requestSide = page.requestSide;
  assign beat.controlPage = page.controlPage;
  assign beat.channel = page.channel;
  assign beat.offset = page.offset;
  assign beat.wData = wData;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (awFire) state <= BURST;
        // Beat count comes from awLen, not from the master
        BURST: if (wFire && remaining == '0) state <= RESP;
        RESP: if (bFire) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (awFire) begin
      page <= decodeAddr(awAddr);
      remaining <= awLen;
      burstId <= awId;
    end else if (wFire) begin
      page.offset <= page.offset + beatStep;
      remaining <= remaining - burstLen_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== logic/portalRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none

module portalRegisters (
  input logic CLK,
  input logic RST_N,
  portalBeatIf.target readBeat,
  portalBeatIf.target writeBeat,
  output logic requestValid,
  output portalPkg::word_t requestData,
  output portalPkg::channel_t requestChannel,
  input logic requestReady,
  input logic indicationValid,
  input portalPkg::word_t indicationData,
  output portalPkg::channel_t indicationChannel,
  output logic indicationTaken,
  input portalPkg::word_t interruptChannel,
  output logic interrupt
);
  import portalPkg::*;

  logic interruptEnable;
  logic channelPending;
  logic indicationRead;
  word_t readWord;

  assign channelPending = interruptChannel != '0;
  assign interrupt = interruptEnable && channelPending;

  // Indication word sits at user offset 0
  assign indicationRead = readBeat.valid && !readBeat.controlPage &&
                          !readBeat.requestSide && readBeat.offset == '0;
  assign indicationTaken = indicationRead && indicationValid;
  assign indicationChannel = readBeat.channel;

  assign requestValid = writeBeat.valid && !writeBeat.controlPage && writeBeat.requestSide;
  assign requestData = writeBeat.wData;
  assign requestChannel = writeBeat.channel;

  always_comb begin
    readWord = '0;
    if (readBeat.controlPage) begin
      case (readBeat.offset)
        INT_STATUS: readWord = word_t'(!readBeat.requestSide && channelPending);
        INT_ENABLE: readWord = word_t'(interruptEnable);
        NUM_TILES: readWord = numTiles;
        QUEUE_STATUS: readWord = readBeat.requestSide ? '0 : interruptChannel;
        PORTAL_ID: readWord = readBeat.requestSide ? requestPortalId : indicationPortalId;
        NUM_PORTALS: readWord = numPortals;
        default: readWord = fillWord;
      endcase
    end else if (readBeat.requestSide) begin
      // Request side reports whether the core can take more
      if (readBeat.offset == 5'h04) begin
        readWord = word_t'(requestReady);
      end
    end else if (readBeat.offset == '0 && indicationValid) begin
      readWord = indicationData;
    end
  end

  assign readBeat.rData = readWord;
  assign writeBeat.rData = '0;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      interruptEnable <= 1'b0;
    end else if (writeBeat.valid && writeBeat.controlPage &&
                 writeBeat.offset == INT_ENABLE) begin
      interruptEnable <= writeBeat.wData[0];
    end
  end

endmodule

`default_nettype wire

// ==== logic/portalBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module portalBridge (
  input logic CLK,
  input logic RST_N,
  input logic arValid,
  output logic arReady,
  input portalPkg::busAddr_t arAddr,
  input portalPkg::burstLen_t arLen,
  input portalPkg::axiId_t arId,
  output logic rValid,
  input logic rReady,
  output portalPkg::word_t rData,
  output portalPkg::axiId_t rId,
  output logic rLast,
  input logic awValid,
  output logic awReady,
  input portalPkg::busAddr_t awAddr,
  input portalPkg::burstLen_t awLen,
  input portalPkg::axiId_t awId,
  input logic wValid,
  output logic wReady,
  input portalPkg::word_t wData,
  output logic bValid,
  input logic bReady,
  output portalPkg::axiId_t bId,
  output logic requestValid,
  output portalPkg::word_t requestData,
  output portalPkg::channel_t requestChannel,
  input logic requestReady,
  input logic indicationValid,
  input portalPkg::word_t indicationData,
  output portalPkg::channel_t indicationChannel,
  output logic indicationTaken,
  input portalPkg::word_t interruptChannel,
  output logic interrupt
);

  portalBeatIf readBeat ();
  portalBeatIf writeBeat ();

  readBurstEngine readEngine (
    .CLK(CLK), .RST_N(RST_N),
    .arValid(arValid), .arReady(arReady), .arAddr(arAddr), .arLen(arLen), .arId(arId),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .beat(readBeat.issuer)
  );

  writeBurstEngine writeEngine (
    .CLK(CLK), .RST_N(RST_N),
    .awValid(awValid), .awReady(awReady), .awAddr(awAddr), .awLen(awLen), .awId(awId),
    .wValid(wValid), .wReady(wReady), .wData(wData),
    .bValid(bValid), .bReady(bReady), .bId(bId),
    .beat(writeBeat.issuer)
  );

  // Both engines meet here
  portalRegisters registers (
    .CLK(CLK), .RST_N(RST_N),
    .readBeat(readBeat.target), .writeBeat(writeBeat.target),
    .requestValid(requestValid), .requestData(requestData),
    .requestChannel(requestChannel), .requestReady(requestReady),
    .indicationValid(indicationValid), .indicationData(indicationData),
    .indicationChannel(indicationChannel), .indicationTaken(indicationTaken),
    .interruptChannel(interruptChannel), .interrupt(interrupt)
  );

endmodule

`default_nettype wire

// ==== bench/portalBridgeChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module portalBridgeChecker (
  input logic CLK,
  input logic arReady, awReady, wReady,
  input logic rValid, rReady, rLast,
  input portalPkg::word_t rData,
  input portalPkg::axiId_t rId,
  input logic bValid, bReady,
  input portalPkg::axiId_t bId,
  input logic requestValid,
  input portalPkg::word_t requestData,
  input portalPkg::channel_t requestChannel,
  input portalPkg::channel_t indicationChannel,
  input logic indicationTaken, interrupt,
  // Expectations from the stimulus side
  input logic pushR, pushB, pushReq, pushTaken, checkIrq, finalCheck,
  input portalPkg::word_t expWord,
  input portalPkg::axiId_t expId,
  input logic expLast, expIrq,
  input portalPkg::channel_t expChan,
  output int checkCount,
  output int errorCount
);
  import portalPkg::*;

  // Packed as last, id, word
  logic [38:0] rQueue[$];
  axiId_t bQueue[$];
  // Packed as channel, word
  logic [33:0] reqQueue[$];
  channel_t takenQueue[$];
  int checks = 0;
  int errors = 0;
  logic [38:0] rExp;
  logic [33:0] reqExp;
  logic rHeld = 1'b0;
  logic bHeld = 1'b0;
  word_t heldRData;
  axiId_t heldBId;

  assign checkCount = checks;
  assign errorCount = errors;

  task automatic compare(input string name, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected 'h%0h, actual 'h%0h",
               $time, name, expected, actual);
    end
  endtask

  always @(posedge CLK) begin
    if (pushR) rQueue.push_back({expLast, expId, expWord});
    if (pushB) bQueue.push_back(expId);
    if (pushReq) reqQueue.push_back({expChan, expWord});
    if (pushTaken) takenQueue.push_back(expChan);
    // A stalled beat must hold
    if (rHeld) begin
      if (!rValid) begin
        errors++;
        $display("rValid dropped at %0t before its beat was accepted", $time);
      end
      compare("rData (stalled)", heldRData, rData);
    end
    if (bHeld) begin
      if (!bValid) begin
        errors++;
        $display("bValid dropped at %0t before the response was accepted", $time);
      end
      compare("bId (stalled)", word_t'(heldBId), word_t'(bId));
    end
    if (rValid && rReady) begin
      if (rQueue.size() == 0) begin
        errors++;
        $display("Extra R beat at %0t with data 'h%0h", $time, rData);
      end else begin
        rExp = rQueue.pop_front();
        compare("rData", rExp[31:0], rData);
        compare("rId", word_t'(rExp[37:32]), word_t'(rId));
        compare("rLast", word_t'(rExp[38]), word_t'(rLast));
      end
    end
    if (bValid && bReady) begin
      if (bQueue.size() == 0) begin
        errors++;
        $display("Extra B response at %0t with id 'h%0h", $time, bId);
      end else begin
        compare("bId", word_t'(bQueue.pop_front()), word_t'(bId));
      end
    end
    if (requestValid) begin
      if (reqQueue.size() == 0) begin
        errors++;
        $display("Extra request strobe at %0t with data 'h%0h", $time, requestData);
      end else begin
        reqExp = reqQueue.pop_front();
        compare("requestData", reqExp[31:0], requestData);
        compare("requestChannel", word_t'(reqExp[33:32]), word_t'(requestChannel));
      end
    end
    if (indicationTaken) begin
      if (takenQueue.size() == 0) begin
        errors++;
        $display("Unexpected indicationTaken pulse at %0t", $time);
      end else begin
        compare("indicationChannel", word_t'(takenQueue.pop_front()),
                word_t'(indicationChannel));
      end
    end
    if (checkIrq) begin
      compare("interrupt", word_t'(expIrq), word_t'(interrupt));
      // Both engines idle between entries
      compare("arReady", 32'd1, word_t'(arReady));
      compare("awReady", 32'd1, word_t'(awReady));
      compare("wReady", 32'd0, word_t'(wReady));
    end
    if (finalCheck &&
        (rQueue.size() + bQueue.size() + reqQueue.size() + takenQueue.size()) != 0) begin
      errors++;
      $display("Never arrived: %0d R beats, %0d B responses, %0d requests, %0d taken pulses",
               rQueue.size(), bQueue.size(), reqQueue.size(), takenQueue.size());
    end
    rHeld = rValid && !rReady;
    bHeld = bValid && !bReady;
    heldRData = rData;
    heldBId = bId;
  end

endmodule

`default_nettype wire

// ==== bench/portalBridgeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module portalBridgeTb;
  import portalPkg::*;

  typedef struct packed {
    logic isWrite;
    busAddr_t addr;
    burstLen_t len;
    axiId_t id;
    word_t seed;
    logic indValid;
    word_t indData;
    word_t intChan;
    logic reqReady;
    logic taken;
    logic irq;
    // Read words or request words in beat order
    logic [0:5][31:0] words;
  } testEntry_t;

  logic CLK, RST_N;
  logic arValid, rReady, awValid, wValid, bReady;
  busAddr_t arAddr, awAddr;
  burstLen_t arLen, awLen;
  axiId_t arId, awId, rId, bId;
  word_t wData, rData, requestData, indicationData, interruptChannel;
  logic arReady, rValid, rLast, awReady, wReady, bValid;
  logic requestValid, requestReady, indicationValid, indicationTaken, interrupt;
  channel_t requestChannel, indicationChannel;
  logic pushR, pushB, pushReq, pushTaken, checkIrq, finalCheck, expLast, expIrq;
  word_t expWord;
  axiId_t expId;
  channel_t expChan;
  int checkCount, errorCount, cycles, cycleLimit, totalBeats;
  integer seed = 32'h6b81;
  testEntry_t tests[13];

  portalBridge i_portalBridge (.*);
  portalBridgeChecker resultChecker (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Random stalls on R and B
  initial begin
    rReady = 1'b0;
    bReady = 1'b0;
    forever begin
      @(posedge CLK);
      #2;
      rReady = ($random(seed) & 3) != 0;
      bReady = ($random(seed) & 1) != 0;
    end
  end

  initial begin
    cycles = 0;
    do begin
      @(posedge CLK);
      cycles++;
    end while (cycles <= cycleLimit);
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic nextCycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic runEntry(input testEntry_t e);
    int beats;
    logic userWrite;
    userWrite = e.isWrite && e.addr[12] && e.addr[11:5] != '0;
    indicationValid = e.indValid;
    indicationData = e.indData;
    interruptChannel = e.intChan;
    requestReady = e.reqReady;
    for (int i = 0; i <= int'(e.len); i++) begin
      pushR = !e.isWrite;
      pushReq = userWrite;
      expWord = e.words[i];
      expId = e.id;
      expLast = i == int'(e.len);
      expChan = e.addr[6:5] - 2'd1;
      nextCycle();
    end
    pushR = 1'b0;
    pushReq = 1'b0;
    pushB = e.isWrite;
    pushTaken = e.taken;
    nextCycle();
    pushB = 1'b0;
    pushTaken = 1'b0;
    if (e.isWrite) begin
      awValid = 1'b1;
      awAddr = e.addr;
      awLen = e.len;
      awId = e.id;
      do @(posedge CLK); while (!awReady);
      #2;
      awValid = 1'b0;
      for (int i = 0; i <= int'(e.len); i++) begin
        wValid = 1'b1;
        wData = e.seed + word_t'(i) * 32'h11;
        do @(posedge CLK); while (!wReady);
        #2;
      end
      wValid = 1'b0;
      do @(posedge CLK); while (!(bValid && bReady));
      #2;
    end else begin
      arValid = 1'b1;
      arAddr = e.addr;
      arLen = e.len;
      arId = e.id;
      do @(posedge CLK); while (!arReady);
      #2;
      arValid = 1'b0;
      beats = 0;
      while (beats <= int'(e.len)) begin
        @(posedge CLK);
        if (rValid && rReady) beats++;
      end
      #2;
    end
    checkIrq = 1'b1;
    expIrq = e.irq;
    nextCycle();
    checkIrq = 1'b0;
  endtask

  initial begin
    // wr, addr, len, id, seed, indValid, indData, intChan, reqReady, taken, irq
    tests[0] = '{0, 13'h1008, 4'd3, 6'h11, 32'h0, 0, 32'h0, 32'd3, 0, 0, 0,
                 {32'd1, 32'd0, 32'd6, 32'd2, 32'd0, 32'd0}};
    tests[1] = '{0, 13'h0008, 4'd3, 6'h22, 32'h0, 0, 32'h0, 32'd3, 0, 0, 0,
                 {32'd1, 32'd3, 32'd5, 32'd2, 32'd0, 32'd0}};
    tests[2] = '{0, 13'h0018, 4'd0, 6'h05, 32'h0, 0, 32'h0, 32'd0, 0, 0, 0,
                 {32'h005A05A0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0}};
    tests[3] = '{1, 13'h1004, 4'd0, 6'h07, 32'h1, 0, 32'h0, 32'd4, 0, 0, 1,
                 {32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0}};
    tests[4] = '{0, 13'h0000, 4'd0, 6'h08, 32'h0, 0, 32'h0, 32'd4, 0, 0, 1,
                 {32'd1, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0}};
    tests[5] = '{1, 13'h0004, 4'd0, 6'h09, 32'h0, 0, 32'h0, 32'd4, 0, 0, 0,
                 {32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0}};
    tests[6] = '{1, 13'h1060, 4'd2, 6'h2A, 32'hA0000000, 0, 32'h0, 32'd0, 0, 0, 0,
                 {32'hA0000000, 32'hA0000011, 32'hA0000022, 32'd0, 32'd0, 32'd0}};
    tests[7] = '{0, 13'h0060, 4'd0, 6'h03, 32'h0, 1, 32'hCAFE1234, 32'd0, 0, 1, 0,
                 {32'hCAFE1234, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0}};
    tests[8] = '{0, 13'h0020, 4'd0, 6'h04, 32'h0, 0, 32'hCAFE1234, 32'd0, 0, 0, 0,
                 {32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0}};
    tests[9] = '{0, 13'h1024, 4'd0, 6'h0C, 32'h0, 0, 32'h0, 32'd0, 1, 0, 0,
                 {32'd1, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0}};
    tests[10] = '{0, 13'h1024, 4'd0, 6'h0D, 32'h0, 0, 32'h0, 32'd0, 0, 0, 0,
                  {32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0}};
    // Offset wraps back to the top of the page
    tests[11] = '{0, 13'h1010, 4'd5, 6'h3F, 32'h0, 0, 32'h0, 32'd0, 0, 0, 0,
                  {32'd6, 32'd2, 32'h005A05A0, 32'h005A05A0, 32'd0, 32'd0}};
    tests[12] = '{1, 13'h1038, 4'd3, 6'h15, 32'h12345678, 0, 32'h0, 32'd0, 0, 0, 0,
                  {32'h12345678, 32'h12345689, 32'h1234569A, 32'h123456AB, 32'd0, 32'd0}};
    totalBeats = 0;
    foreach (tests[n]) totalBeats += int'(tests[n].len) + 1;
    cycleLimit = 40 * totalBeats + 100;
    arValid = 1'b0;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    awValid = 1'b0;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    wValid = 1'b0;
    wData = '0;
    requestReady = 1'b0;
    indicationValid = 1'b0;
    indicationData = '0;
    interruptChannel = '0;
    pushR = 1'b0;
    pushB = 1'b0;
    pushReq = 1'b0;
    pushTaken = 1'b0;
    checkIrq = 1'b0;
    finalCheck = 1'b0;
    expWord = '0;
    expId = '0;
    expLast = 1'b0;
    expIrq = 1'b0;
    expChan = '0;
    RST_N = 1'b0;
    repeat (3) @(posedge CLK);
    #2;
    RST_N = 1'b1;
    foreach (tests[n]) runEntry(tests[n]);
    finalCheck = 1'b1;
    nextCycle();
    finalCheck = 1'b0;
    nextCycle();
    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/portalPkg.sv
logic/portalBeatIf.sv
logic/readBurstEngine.sv
logic/writeBurstEngine.sv
logic/portalRegisters.sv
logic/portalBridge.sv
bench/portalBridgeChecker.sv
bench/portalBridgeTb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module portalBridgeTb -o portalBridgeSim \
  && ./obj_dir/portalBridgeSim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
